// ==== src/rv_cfg.svh ====
// data, instruction and register file widths for the rv64 pipeline
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and pc width
`define RV_XLEN 64

// instruction word width
`define RV_INST_W 32

// register address width
`define RV_REG_ADDR_W 5

// architectural register count, x0 included
`define RV_NUM_REGS 32

`endif

// ==== src/rv_pkg.sv ====
// opcode classes, alu operation enumeration and operand source selects
package rv_pkg;

  // major opcode, inst[6:2]
  typedef enum logic [4:0] {
    OPC_OP_IMM    = 5'b00100,
    OPC_AUIPC     = 5'b00101,
    OPC_OP_IMM_32 = 5'b00110,
    OPC_OP        = 5'b01100,
    OPC_LUI       = 5'b01101,
    OPC_OP_32     = 5'b01110,
    OPC_JALR      = 5'b11001,
    OPC_JAL       = 5'b11011
  } opclass_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    SRC_A_REG,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_e;

  // operand b source
  typedef enum logic {
    SRC_B_REG,
    SRC_B_IMM
  } src_b_e;

endpackage

// ==== src/rv_decode.sv ====
// decode stage: field split, classification, immediates, forwarding and decode/execute register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      inst_valid_i,
  input  logic [`RV_INST_W-1:0]     inst_i,
  input  logic [`RV_XLEN-1:0]       pc_i,
  input  logic [`RV_XLEN-1:0]       rs1_data_i,
  input  logic [`RV_XLEN-1:0]       rs2_data_i,
  input  logic                      fwd_ex_valid_i,
  input  logic [`RV_REG_ADDR_W-1:0] fwd_ex_rd_i,
  input  logic [`RV_XLEN-1:0]       fwd_ex_data_i,
  input  logic                      wb_valid_i,
  input  logic [`RV_REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`RV_XLEN-1:0]       wb_data_i,
  output logic [`RV_REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`RV_REG_ADDR_W-1:0] rs2_addr_o,
  output logic                      ex_valid_o,
  output rv_pkg::alu_op_e           ex_alu_op_o,
  output logic                      ex_word_o,
  output logic                      ex_jump_o,
  output logic [`RV_REG_ADDR_W-1:0] ex_rd_o,
  output logic [`RV_XLEN-1:0]       ex_op_a_o,
  output logic [`RV_XLEN-1:0]       ex_op_b_o,
  output logic [`RV_XLEN-1:0]       ex_imm_o,
  output logic [`RV_XLEN-1:0]       ex_pc_o
);

  rv_pkg::opclass_e          opclass;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_XLEN-1:0]       imm_i;
  logic [`RV_XLEN-1:0]       imm_u;
  logic [`RV_XLEN-1:0]       imm_j;
  logic                      f7_zero;
  logic                      f7_alt;
  logic                      legal;
  rv_pkg::alu_op_e           funct_op;
  rv_pkg::alu_op_e           alu_op;
  rv_pkg::src_a_e            src_a;
  rv_pkg::src_b_e            src_b;
  logic [`RV_XLEN-1:0]       imm;
  logic                      word;
  logic                      jump;
  logic [`RV_XLEN-1:0]       rs1_val;
  logic [`RV_XLEN-1:0]       rs2_val;
  logic [`RV_XLEN-1:0]       op_a;
  logic [`RV_XLEN-1:0]       op_b;

  assign opclass = rv_pkg::opclass_e'(inst_i[6:2]);
  assign rd      = inst_i[11:7];
  assign funct3  = inst_i[14:12];
  assign rs1     = inst_i[19:15];
  assign rs2     = inst_i[24:20];
  assign funct7  = inst_i[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // only the kept rv64i subset is legal, everything else is a bubble
  always_comb begin
    legal = 1'b0;
    if (inst_i[1:0] == 2'b11) begin
      case (opclass)
        rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL: legal = 1'b1;
        rv_pkg::OPC_JALR: legal = (funct3 == 3'b000);
        rv_pkg::OPC_OP_IMM: begin
          case (funct3)
            3'b001:  legal = (inst_i[31:26] == 6'b000000);
            3'b101:  legal = (inst_i[31:26] == 6'b000000) || (inst_i[31:26] == 6'b010000);
            default: legal = 1'b1;
          endcase
        end
        rv_pkg::OPC_OP_IMM_32: begin
          case (funct3)
            3'b000:  legal = 1'b1;
            3'b001:  legal = f7_zero;
            3'b101:  legal = f7_zero || f7_alt;
            default: legal = 1'b0;
          endcase
        end
        rv_pkg::OPC_OP: legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        rv_pkg::OPC_OP_32: begin
          legal = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) &&
                  (f7_zero || (f7_alt && funct3 != 3'b001));
        end
        default: legal = 1'b0;
      endcase
    end
  end

  // inst[5] separates register forms, where inst[30] selects sub
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (inst_i[5] && inst_i[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  funct_op = rv_pkg::ALU_SLL;
      3'b010:  funct_op = rv_pkg::ALU_SLT;
      3'b011:  funct_op = rv_pkg::ALU_SLTU;
      3'b100:  funct_op = rv_pkg::ALU_XOR;
      3'b101:  funct_op = inst_i[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  funct_op = rv_pkg::ALU_OR;
      default: funct_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    alu_op = rv_pkg::ALU_ADD;
    src_a  = rv_pkg::SRC_A_REG;
    src_b  = rv_pkg::SRC_B_IMM;
    imm    = imm_i;
    word   = 1'b0;
    jump   = 1'b0;
    case (opclass)
      rv_pkg::OPC_LUI: begin
        alu_op = rv_pkg::ALU_PASS_B;
        src_a  = rv_pkg::SRC_A_ZERO;
        imm    = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        src_a = rv_pkg::SRC_A_PC;
        imm   = imm_u;
      end
      // jal carries pc on operand a so execute forms both targets alike
      rv_pkg::OPC_JAL: begin
        src_a = rv_pkg::SRC_A_PC;
        imm   = imm_j;
        jump  = 1'b1;
      end
      rv_pkg::OPC_JALR: jump = 1'b1;
      rv_pkg::OPC_OP_IMM: alu_op = funct_op;
      rv_pkg::OPC_OP_IMM_32: begin
        alu_op = funct_op;
        word   = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        alu_op = funct_op;
        src_b  = rv_pkg::SRC_B_REG;
      end
      rv_pkg::OPC_OP_32: begin
        alu_op = funct_op;
        src_b  = rv_pkg::SRC_B_REG;
        word   = 1'b1;
      end
      default: ;
    endcase
  end

  // execute result first, then write-back, then register file
  function automatic logic [`RV_XLEN-1:0] fwd_value(
    input logic [`RV_REG_ADDR_W-1:0] addr,
    input logic [`RV_XLEN-1:0]       rf_data
  );
    if (addr == '0)
      return '0;
    else if (fwd_ex_valid_i && fwd_ex_rd_i == addr)
      return fwd_ex_data_i;
    else if (wb_valid_i && wb_addr_i == addr)
      return wb_data_i;
    else
      return rf_data;
  endfunction

  always_comb begin
    rs1_val = fwd_value(rs1, rs1_data_i);
    rs2_val = fwd_value(rs2, rs2_data_i);
    case (src_a)
      rv_pkg::SRC_A_REG: op_a = rs1_val;
      rv_pkg::SRC_A_PC:  op_a = pc_i;
      default:           op_a = '0;
    endcase
    op_b = (src_b == rv_pkg::SRC_B_REG) ? rs2_val : imm;
  end

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
      ex_jump_o  <= 1'b0;
    end else begin
      ex_valid_o <= inst_valid_i && legal && (rd != '0);
      ex_jump_o  <= inst_valid_i && legal && jump;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op_o <= alu_op;
    ex_word_o   <= word;
    ex_rd_o     <= rd;
    ex_op_a_o   <= op_a;
    ex_op_b_o   <= op_b;
    ex_imm_o    <= imm;
    ex_pc_o     <= pc_i;
  end

endmodule

// ==== src/rv_execute.sv ====
// execute stage: 64-bit and word alu, jump link and target, execute/result register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      ex_valid_i,
  input  rv_pkg::alu_op_e           ex_alu_op_i,
  input  logic                      ex_word_i,
  input  logic                      ex_jump_i,
  input  logic [`RV_REG_ADDR_W-1:0] ex_rd_i,
  input  logic [`RV_XLEN-1:0]       ex_op_a_i,
  input  logic [`RV_XLEN-1:0]       ex_op_b_i,
  input  logic [`RV_XLEN-1:0]       ex_imm_i,
  input  logic [`RV_XLEN-1:0]       ex_pc_i,
  output logic                      fwd_ex_valid_o,
  output logic [`RV_REG_ADDR_W-1:0] fwd_ex_rd_o,
  output logic [`RV_XLEN-1:0]       fwd_ex_data_o,
  output logic                      wb_valid_o,
  output logic [`RV_REG_ADDR_W-1:0] wb_addr_o,
  output logic [`RV_XLEN-1:0]       wb_data_o,
  output logic                      redirect_valid_o,
  output logic [`RV_XLEN-1:0]       redirect_pc_o
);

  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] target;
  logic [5:0]          shamt;
  logic [31:0]         a_w;
  logic [31:0]         b_w;
  logic [31:0]         word_raw;

  assign shamt = ex_op_b_i[5:0];

  always_comb begin
    case (ex_alu_op_i)
      rv_pkg::ALU_ADD:    alu_res = ex_op_a_i + ex_op_b_i;
      rv_pkg::ALU_SUB:    alu_res = ex_op_a_i - ex_op_b_i;
      rv_pkg::ALU_SLL:    alu_res = ex_op_a_i << shamt;
      rv_pkg::ALU_SLT:    alu_res = {63'b0, $signed(ex_op_a_i) < $signed(ex_op_b_i)};
      rv_pkg::ALU_SLTU:   alu_res = {63'b0, ex_op_a_i < ex_op_b_i};
      rv_pkg::ALU_XOR:    alu_res = ex_op_a_i ^ ex_op_b_i;
      rv_pkg::ALU_SRL:    alu_res = ex_op_a_i >> shamt;
      rv_pkg::ALU_SRA:    alu_res = $signed(ex_op_a_i) >>> shamt;
      rv_pkg::ALU_OR:     alu_res = ex_op_a_i | ex_op_b_i;
      rv_pkg::ALU_AND:    alu_res = ex_op_a_i & ex_op_b_i;
      rv_pkg::ALU_PASS_B: alu_res = ex_op_b_i;
      default:            alu_res = '0;
    endcase
  end

  // word ops, 5-bit shift amount
  assign a_w = ex_op_a_i[31:0];
  assign b_w = ex_op_b_i[31:0];

  always_comb begin
    case (ex_alu_op_i)
      rv_pkg::ALU_ADD: word_raw = a_w + b_w;
      rv_pkg::ALU_SUB: word_raw = a_w - b_w;
      rv_pkg::ALU_SLL: word_raw = a_w << b_w[4:0];
      rv_pkg::ALU_SRL: word_raw = a_w >> b_w[4:0];
      rv_pkg::ALU_SRA: word_raw = $signed(a_w) >>> b_w[4:0];
      default:         word_raw = '0;
    endcase
  end

  always_comb begin
    if (ex_jump_i)
      result = ex_pc_i + `RV_XLEN'd4;
    else if (ex_word_i)
      result = {{(`RV_XLEN-32){word_raw[31]}}, word_raw};
    else
      result = alu_res;
  end

  // operand a holds pc for jal and rs1 for jalr
  assign target = (ex_op_a_i + ex_imm_i) & ~`RV_XLEN'd1;

  assign fwd_ex_valid_o = ex_valid_i;
  assign fwd_ex_rd_o    = ex_rd_i;
  assign fwd_ex_data_o  = result;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_o       <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      wb_valid_o       <= ex_valid_i;
      redirect_valid_o <= ex_jump_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr_o     <= ex_rd_i;
    wb_data_o     <= result;
    redirect_pc_o <= target;
  end

endmodule

// ==== src/rv_result.sv ====
// result stage: integer register file with two read ports and the write-back port
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_result (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
  input  logic                      wb_valid_i,
  input  logic [`RV_REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`RV_XLEN-1:0]       wb_data_i,
  output logic [`RV_XLEN-1:0]       rs1_data_o,
  output logic [`RV_XLEN-1:0]       rs2_data_o
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid_i && wb_addr_i != '0) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // combinational reads
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== src/rv_alu_pipe.sv ====
// top level: decode, execute and result stages of the rv64 integer pipeline
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu_pipe (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      inst_valid_i,
  input  logic [`RV_INST_W-1:0]     inst_i,
  input  logic [`RV_XLEN-1:0]       pc_i,
  output logic                      wb_valid_o,
  output logic [`RV_REG_ADDR_W-1:0] wb_addr_o,
  output logic [`RV_XLEN-1:0]       wb_data_o,
  output logic                      redirect_valid_o,
  output logic [`RV_XLEN-1:0]       redirect_pc_o
);

  logic [`RV_REG_ADDR_W-1:0] rs1_addr;
  logic [`RV_REG_ADDR_W-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic                      ex_valid;
  rv_pkg::alu_op_e           ex_alu_op;
  logic                      ex_word;
  logic                      ex_jump;
  logic [`RV_REG_ADDR_W-1:0] ex_rd;
  logic [`RV_XLEN-1:0]       ex_op_a;
  logic [`RV_XLEN-1:0]       ex_op_b;
  logic [`RV_XLEN-1:0]       ex_imm;
  logic [`RV_XLEN-1:0]       ex_pc;
  logic                      fwd_ex_valid;
  logic [`RV_REG_ADDR_W-1:0] fwd_ex_rd;
  logic [`RV_XLEN-1:0]       fwd_ex_data;
  logic                      wb_valid;
  logic [`RV_REG_ADDR_W-1:0] wb_addr;
  logic [`RV_XLEN-1:0]       wb_data;

  rv_decode u_decode (
    .clk            (clk),
    .reset_i        (reset_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .pc_i           (pc_i),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .fwd_ex_valid_i (fwd_ex_valid),
    .fwd_ex_rd_i    (fwd_ex_rd),
    .fwd_ex_data_i  (fwd_ex_data),
    .wb_valid_i     (wb_valid),
    .wb_addr_i      (wb_addr),
    .wb_data_i      (wb_data),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .ex_valid_o     (ex_valid),
    .ex_alu_op_o    (ex_alu_op),
    .ex_word_o      (ex_word),
    .ex_jump_o      (ex_jump),
    .ex_rd_o        (ex_rd),
    .ex_op_a_o      (ex_op_a),
    .ex_op_b_o      (ex_op_b),
    .ex_imm_o       (ex_imm),
    .ex_pc_o        (ex_pc)
  );

  rv_execute u_execute (
    .clk              (clk),
    .reset_i          (reset_i),
    .ex_valid_i       (ex_valid),
    .ex_alu_op_i      (ex_alu_op),
    .ex_word_i        (ex_word),
    .ex_jump_i        (ex_jump),
    .ex_rd_i          (ex_rd),
    .ex_op_a_i        (ex_op_a),
    .ex_op_b_i        (ex_op_b),
    .ex_imm_i         (ex_imm),
    .ex_pc_i          (ex_pc),
    .fwd_ex_valid_o   (fwd_ex_valid),
    .fwd_ex_rd_o      (fwd_ex_rd),
    .fwd_ex_data_o    (fwd_ex_data),
    .wb_valid_o       (wb_valid),
    .wb_addr_o        (wb_addr),
    .wb_data_o        (wb_data),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  rv_result u_result (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wb_valid_i (wb_valid),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  assign wb_valid_o = wb_valid;
  assign wb_addr_o  = wb_addr;
  assign wb_data_o  = wb_data;

endmodule

// ==== tb/rv_ref_model.svh ====
// instruction encoders, shadow register file and reference alu for the pipeline testbench
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam logic [6:0] ENC_OP_IMM    = 7'b0010011;
localparam logic [6:0] ENC_AUIPC     = 7'b0010111;
localparam logic [6:0] ENC_OP_IMM_32 = 7'b0011011;
localparam logic [6:0] ENC_OP        = 7'b0110011;
localparam logic [6:0] ENC_LUI       = 7'b0110111;
localparam logic [6:0] ENC_OP_32     = 7'b0111011;
localparam logic [6:0] ENC_JALR      = 7'b1100111;
localparam logic [6:0] ENC_JAL       = 7'b1101111;
localparam logic [6:0] ENC_STORE     = 7'b0100011;

// architectural state, updated in issue order
logic [`RV_XLEN-1:0] shadow [0:`RV_NUM_REGS-1];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, ENC_JAL};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], ENC_STORE};
endfunction

function automatic logic [63:0] sext12(input logic [11:0] imm);
  return {{52{imm[11]}}, imm};
endfunction

// isa semantics; alt means sub for funct3 0 and arithmetic shift for funct3 5
function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic word, input logic [63:0] a,
                                        input logic [63:0] b);
  logic [63:0] r;
  logic [31:0] w;
  logic [5:0]  sh;
  sh = word ? {1'b0, b[4:0]} : b[5:0];
  if (word) begin
    case (f3)
      3'd0:    w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'd1:    w = a[31:0] << sh;
      default: w = (alt && a[31]) ? (a[31:0] >> sh) | ~(32'hffff_ffff >> sh) : a[31:0] >> sh;
    endcase
    r = {{32{w[31]}}, w};
  end else begin
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      // signed compare by flipping the sign bits
      3'd2: r = ({~a[63], a[62:0]} < {~b[63], b[62:0]}) ? 64'd1 : 64'd0;
      3'd3: r = (a < b) ? 64'd1 : 64'd0;
      3'd4: r = a ^ b;
      3'd5: r = (alt && a[63]) ? (a >> sh) | ~(64'hffff_ffff_ffff_ffff >> sh) : a >> sh;
      3'd6: r = a | b;
      default: r = a & b;
    endcase
  end
  return r;
endfunction

`endif

// ==== tb/tb_rv_alu_pipe.sv ====
// testbench for the rv64 alu pipeline with clock, reset, stimulus, assertions and pass/fail
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_alu_pipe;

  logic                      clk;
  logic                      reset_i;
  logic                      inst_valid_i;
  logic [`RV_INST_W-1:0]     inst_i;
  logic [`RV_XLEN-1:0]       pc_i;
  logic                      wb_valid_o;
  logic [`RV_REG_ADDR_W-1:0] wb_addr_o;
  logic [`RV_XLEN-1:0]       wb_data_o;
  logic                      redirect_valid_o;
  logic [`RV_XLEN-1:0]       redirect_pc_o;

  typedef struct packed {
    logic [4:0]  addr;
    logic [63:0] data;
    logic [31:0] due;
  } wb_exp_t;

  typedef struct packed {
    logic [63:0] target;
    logic [31:0] due;
  } redir_exp_t;

  wb_exp_t     wb_q[$];
  redir_exp_t  redir_q[$];
  wb_exp_t     wb_head;
  redir_exp_t  redir_head;
  logic [31:0] cyc = '0;
  logic [63:0] pc;
  logic [31:0] rnd;
  integer      seed;

  `include "rv_ref_model.svh"

  rv_alu_pipe UUT (
    .clk              (clk),
    .reset_i          (reset_i),
    .inst_valid_i     (inst_valid_i),
    .inst_i           (inst_i),
    .pc_i             (pc_i),
    .wb_valid_o       (wb_valid_o),
    .wb_addr_o        (wb_addr_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  assert property (@(posedge clk) reset_i |=> !wb_valid_o)
    else stop_on_error($sformatf("FAIL wb_valid_o: got %h expected 0", $sampled(wb_valid_o)));
  assert property (@(posedge clk) reset_i |=> !redirect_valid_o)
    else stop_on_error($sformatf("FAIL redirect_valid_o: got %h expected 0",
                                 $sampled(redirect_valid_o)));
  assert property (@(posedge clk) disable iff (reset_i) redirect_valid_o |-> !redirect_pc_o[0])
    else stop_on_error($sformatf("FAIL redirect_pc_o: got %h with bit 0 set",
                                 $sampled(redirect_pc_o)));
  assert property (@(posedge clk) disable iff (reset_i) wb_valid_o |-> wb_addr_o != '0)
    else stop_on_error($sformatf("FAIL wb_addr_o: got %h for a valid write", $sampled(wb_addr_o)));

  // write-back and redirect against the expected queues
  always @(negedge clk) begin
    if (!reset_i) begin
      if (wb_valid_o) begin
        assert (wb_q.size() != 0)
          else stop_on_error($sformatf("FAIL wb_valid_o: got %h expected 0", wb_valid_o));
        wb_head = wb_q.pop_front();
        assert (wb_addr_o == wb_head.addr)
          else stop_on_error($sformatf("FAIL wb_addr_o: got %h expected %h",
                                       wb_addr_o, wb_head.addr));
        assert (wb_data_o == wb_head.data)
          else stop_on_error($sformatf("FAIL wb_data_o: got %h expected %h",
                                       wb_data_o, wb_head.data));
        assert (cyc == wb_head.due)
          else stop_on_error("write-back arrived in the wrong cycle");
      end else begin
        assert (wb_q.size() == 0 || wb_q[0].due != cyc)
          else stop_on_error("an expected write-back did not appear");
      end
      if (redirect_valid_o) begin
        assert (redir_q.size() != 0)
          else stop_on_error($sformatf("FAIL redirect_valid_o: got %h expected 0",
                                       redirect_valid_o));
        redir_head = redir_q.pop_front();
        assert (redirect_pc_o == redir_head.target)
          else stop_on_error($sformatf("FAIL redirect_pc_o: got %h expected %h",
                                       redirect_pc_o, redir_head.target));
        assert (cyc == redir_head.due)
          else stop_on_error("redirect arrived in the wrong cycle");
      end else begin
        assert (redir_q.size() == 0 || redir_q[0].due != cyc)
          else stop_on_error("an expected redirect did not appear");
      end
    end
  end

  task automatic send(input logic [31:0] inst, input logic [4:0] rd,
                      input logic [63:0] value, input logic writes);
    wb_exp_t e;
    @(negedge clk);
    inst_valid_i = 1'b1;
    inst_i       = inst;
    pc_i         = pc;
    pc           = pc + 64'd4;
    if (writes && rd != 5'd0) begin
      e.addr = rd;
      e.data = value;
      e.due  = cyc + 32'd2;
      wb_q.push_back(e);
      shadow[rd] = value;
    end
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    inst_valid_i = 1'b0;
    while ((wb_q.size() != 0 || redir_q.size() != 0) && n < limit) begin
      @(posedge clk);
      n++;
    end
    assert (wb_q.size() == 0 && redir_q.size() == 0)
      else stop_on_error("timeout waiting for the pipeline to drain");
  endtask

  // a jal to x1 is in execute when reset hits, so it must leave no trace
  task automatic reset_mid_flight();
    @(negedge clk);
    inst_valid_i = 1'b1;
    inst_i       = enc_j(21'h000008, 5'd1);
    pc_i         = pc;
    @(negedge clk);
    inst_valid_i = 1'b0;
    reset_i      = 1'b1;
    repeat (3) @(negedge clk);
    reset_i = 1'b0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      shadow[i] = '0;
    end
  endtask

  task automatic op_rr(input logic [2:0] f3, input logic alt, input logic word,
                       input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    send(enc_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, word ? ENC_OP_32 : ENC_OP),
         rd, ref_alu(f3, alt, word, shadow[rs1], shadow[rs2]), 1'b1);
  endtask

  // srai and sraiw carry the arithmetic flag in imm[10]
  task automatic op_ri(input logic [2:0] f3, input logic word, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [11:0] imm);
    send(enc_i(imm, rs1, f3, rd, word ? ENC_OP_IMM_32 : ENC_OP_IMM), rd,
         ref_alu(f3, f3 == 3'd5 && imm[10], word, shadow[rs1], sext12(imm)), 1'b1);
  endtask

  task automatic op_upper(input logic pc_rel, input logic [4:0] rd, input logic [19:0] imm);
    logic [63:0] value;
    value = {{32{imm[19]}}, imm, 12'b0};
    if (pc_rel)
      value = value + pc;
    send({imm, rd, pc_rel ? ENC_AUIPC : ENC_LUI}, rd, value, 1'b1);
  endtask

  // jal when use_reg is low, jalr otherwise; waits for the redirect
  task automatic jump(input logic use_reg, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [20:0] off);
    logic [63:0] target;
    logic [31:0] inst;
    redir_exp_t  r;
    if (use_reg) begin
      target = (shadow[rs1] + sext12(off[11:0])) & ~64'd1;
      inst   = enc_i(off[11:0], rs1, 3'b000, rd, ENC_JALR);
    end else begin
      target = pc + {{43{off[20]}}, off};
      inst   = enc_j(off, rd);
    end
    send(inst, rd, pc + 64'd4, 1'b1);
    r.target = target;
    r.due    = cyc + 32'd2;
    redir_q.push_back(r);
    drain(16);
    pc = target;
  endtask

  task automatic random_op();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  f3w;
    logic        alt;
    logic [11:0] imm;
    rnd = $random(seed);
    rd  = {2'b00, rnd[2:0]};
    rs1 = {2'b00, rnd[5:3]};
    rs2 = {2'b00, rnd[8:6]};
    f3  = rnd[11:9];
    f3w = (rnd[10:9] == 2'd0) ? 3'd0 : (rnd[10:9] == 2'd1) ? 3'd1 : 3'd5;
    alt = rnd[12];
    imm = rnd[24:13];
    case (rnd[27:25])
      3'd0, 3'd1: op_rr(f3, alt && (f3 == 3'd0 || f3 == 3'd5), 1'b0, rd, rs1, rs2);
      3'd2, 3'd3: begin
        if (f3 == 3'd1 || f3 == 3'd5)
          imm[11:6] = (f3 == 3'd5 && alt) ? 6'b010000 : 6'b000000;
        op_ri(f3, 1'b0, rd, rs1, imm);
      end
      3'd4: op_rr(f3w, alt && f3w != 3'd1, 1'b1, rd, rs1, rs2);
      3'd5: begin
        if (f3w != 3'd0)
          imm[11:5] = (f3w == 3'd5 && alt) ? 7'b0100000 : 7'b0000000;
        op_ri(f3w, 1'b1, rd, rs1, imm);
      end
      3'd6: op_upper(1'b0, rd, rnd[31:12]);
      default: op_upper(1'b1, rd, rnd[31:12]);
    endcase
  endtask

  initial begin
    seed         = 32'heb0b;
    reset_i      = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    pc           = 64'h8000_0000;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    repeat (3) @(negedge clk);
    reset_i = 1'b0;

    // x1 is still zero
    op_ri(3'd0, 1'b0, 5'd2, 5'd1, 12'h123);
    drain(16);

    // seed x1..x7 through distance-1 chains
    for (int r = 1; r < 8; r++) begin
      rnd = $random(seed);
      op_upper(1'b0, 5'(r), rnd[19:0]);
      op_ri(3'd0, 1'b0, 5'(r), 5'(r), rnd[31:20]);
      op_ri(3'd1, 1'b0, 5'(r), 5'(r), {7'b0, rnd[4:0]});
      op_rr(3'd4, 1'b0, 1'b0, 5'(r), 5'(r), 5'(r - 1));
    end
    for (int k = 0; k < 80; k++) begin
      random_op();
    end
    drain(16);

    // execute beats write-back, then distance 2 and x0
    op_ri(3'd0, 1'b0, 5'd3, 5'd0, 12'h005);
    op_ri(3'd0, 1'b0, 5'd3, 5'd3, 12'h001);
    op_rr(3'd0, 1'b0, 1'b0, 5'd4, 5'd3, 5'd3);
    op_rr(3'd0, 1'b1, 1'b0, 5'd5, 5'd3, 5'd4);
    op_ri(3'd0, 1'b0, 5'd0, 5'd4, 12'h007);
    op_rr(3'd6, 1'b0, 1'b0, 5'd6, 5'd0, 5'd4);
    drain(16);

    // word results that need sign extension
    op_upper(1'b0, 5'd8, 20'h7ffff);
    op_rr(3'd0, 1'b0, 1'b1, 5'd9, 5'd8, 5'd8);
    op_ri(3'd5, 1'b1, 5'd10, 5'd9, 12'h404);
    op_ri(3'd1, 1'b1, 5'd11, 5'd8, 12'h001);
    op_rr(3'd5, 1'b0, 1'b1, 5'd12, 5'd9, 5'd11);
    op_rr(3'd0, 1'b1, 1'b1, 5'd13, 5'd0, 5'd8);
    drain(16);

    jump(1'b0, 5'd1, 5'd0, 21'h000010);
    jump(1'b1, 5'd14, 5'd2, 21'h0000a5);
    jump(1'b1, 5'd14, 5'd14, 21'h000ffb);
    jump(1'b0, 5'd0, 5'd0, 21'h1ffff8);

    // x1 and x3 were written, so they read zero only if reset clears the register file
    reset_mid_flight();
    op_ri(3'd0, 1'b0, 5'd2, 5'd1, 12'h123);

    // a store is unsupported and must leave no write
    send(enc_s(12'h010, 5'd3, 5'd4), 5'd3, 64'd0, 1'b0);
    op_ri(3'd4, 1'b0, 5'd15, 5'd3, 12'hfff);
    drain(16);
    repeat (4) @(negedge clk);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== rv_alu_pipe.f ====
+incdir+src
+incdir+tb
src/rv_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_alu_pipe.sv
tb/tb_rv_alu_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_alu_pipe
FILELIST  ?= rv_alu_pipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := src/rv_cfg.svh src/rv_pkg.sv src/rv_decode.sv src/rv_execute.sv \
        src/rv_result.sv src/rv_alu_pipe.sv tb/rv_ref_model.svh tb/tb_rv_alu_pipe.sv
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
